//--- Bender.yml
package:
  name: pool

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/pool_pkg.sv
      - verilog/pool_fifo.sv
      - verilog/pool_ingress.sv
      - verilog/pool_row_max.sv
      - verilog/pool_col_max.sv
      - verilog/pool_pack.sv
      - verilog/pool_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/pool_top_props.sv
      - test/tb_pool_top.sv

//--- pool.f
+incdir+verilog
verilog/pool_pkg.sv
verilog/pool_fifo.sv
verilog/pool_ingress.sv
verilog/pool_row_max.sv
verilog/pool_col_max.sv
verilog/pool_pack.sv
verilog/pool_top.sv
test/pool_top_props.sv
test/tb_pool_top.sv

//--- test/pool_top_props.sv
// handshake assertions for the pooling engine ports; bound into pool_top for simulation
`timescale 1ns/1ps

module pool_top_props
  import pool_pkg::*;
(
  input logic  clk,
  input logic  reset,
  input logic  in_req,
  input logic  in_ack,
  input logic  out_req,
  input logic  out_ack,
  input word_t out_data
);

  // ack only answers a request seen on the previous edge
  ack_needs_req: assert property (@(posedge clk) disable iff (reset)
    $rose(in_ack) |-> $past(in_req))
    else $error("in_ack rose without in_req");

  out_data_held: assert property (@(posedge clk) disable iff (reset)
    (out_req && !out_ack) |=> $stable(out_data))
    else $error("out_data changed while waiting for out_ack");

  // req may only drop once the sink has acked
  req_held: assert property (@(posedge clk) disable iff (reset)
    $fell(out_req) |-> $past(out_ack))
    else $error("out_req fell before out_ack");

  idle_after_reset: assert property (@(posedge clk)
    reset |=> (!in_ack && !out_req))
    else $error("port handshake lines high after reset");

endmodule

bind pool_top pool_top_props props_inst (
  .clk      (clk),
  .reset    (reset),
  .in_req   (in_req),
  .in_ack   (in_ack),
  .out_req  (out_req),
  .out_ack  (out_ack),
  .out_data (out_data)
);

//--- test/tb_pool_top.sv
// self-checking testbench for the pooling engine; compile with pool.f, top module tb_pool_top
`timescale 1ns/1ps

`include "pool_defs.svh"

module tb_pool_top
  import pool_pkg::*;
();

  localparam int FRAME_PIX   = `POOL_FRAME_ROWS * `POOL_ROW_PIX;
  localparam int FRAME_WORDS = FRAME_PIX / `POOL_LANES;
  localparam int TIMEOUT     = 2000; // cycles per wait

  logic  clk;
  logic  reset;
  logic  kernel3;
  logic  in_req;
  word_t in_data;
  logic  out_ack;
  logic  in_ack;
  logic  out_req;
  word_t out_data;

  pixel_t      frame [FRAME_PIX]; // raster order
  word_t       exp_q [$];
  word_t       got_q [$];
  word_t       last_word;
  logic [31:0] src_seed = 32'd20021;
  logic [31:0] snk_seed = 32'd20021; // own stream so ack timing is independent
  int          sink_delay_max = 0;
  int          rx_count = 0;
  int          checks = 0;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          err0;

  pool_top pool_top_inst (
    .clk      (clk),
    .reset    (reset),
    .kernel3  (kernel3),
    .in_req   (in_req),
    .in_data  (in_data),
    .out_ack  (out_ack),
    .in_ack   (in_ack),
    .out_req  (out_req),
    .out_data (out_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ******************************
  // helpers
  // ******************************

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [15:0] rand_bits();
    src_seed = lcg_step(src_seed);
    return src_seed[31:16]; // upper bits, better period
  endfunction

  function automatic int sink_rand(input int n);
    snk_seed = lcg_step(snk_seed);
    return int'(snk_seed[30:16]) % n;
  endfunction

  // window maxima in raster order, four per word, last word zero-filled
  function automatic void pool_ref(input pixel_t f [FRAME_PIX], input int k);
    pixel_t m;
    word_t  w;
    int     lane;
    int     r;
    int     c;
    int     dy;
    int     dx;
    lane = 0;
    w = '0;
    for (r = 0; r + k <= `POOL_FRAME_ROWS; r += k)
      for (c = 0; c + k <= `POOL_ROW_PIX; c += k)
      begin
        m = f[r*`POOL_ROW_PIX + c];
        for (dy = 0; dy < k; dy++)
          for (dx = 0; dx < k; dx++)
            if (f[(r+dy)*`POOL_ROW_PIX + c + dx] > m)
              m = f[(r+dy)*`POOL_ROW_PIX + c + dx];
        w[lane*`POOL_PIX_W +: `POOL_PIX_W] = m;
        lane++;
        if (lane == `POOL_LANES)
        begin
          exp_q.push_back(w);
          w = '0;
          lane = 0;
        end
      end
    if (lane != 0)
      exp_q.push_back(w);
  endfunction

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic fill_random();
    for (int i = 0; i < FRAME_PIX; i++)
      frame[i] = pixel_t'(rand_bits());
  endtask

  // mostly negative, with flat windows at -1 and at the most negative value
  task automatic fill_negative();
    for (int i = 0; i < FRAME_PIX; i++)
      frame[i] = (i % 9 == 4) ? pixel_t'(rand_bits() & 16'h00ff) :
                                pixel_t'(rand_bits() | 16'h8000);
    for (int r = 0; r < 3; r++)
      for (int c = 0; c < 3; c++)
      begin
        frame[r*`POOL_ROW_PIX + c]           = -16'sd1;
        frame[(r+3)*`POOL_ROW_PIX + c + 9]   = 16'sh8000;
      end
  endtask

  // ******************************
  // input source
  // ******************************

  task automatic send_word(input word_t w);
    int t;
    in_data = w;
    in_req = 1'b1;
    t = 0;
    while (!in_ack && t < TIMEOUT)
    begin
      step();
      t++;
    end
    if (!in_ack)
    begin
      $display("ERROR: no in_ack for input word at %0t ns", $time);
      errors++;
    end
    in_req = 1'b0;
    t = 0;
    while (in_ack && t < TIMEOUT)
    begin
      step();
      t++;
    end
    if (in_ack)
    begin
      $display("ERROR: in_ack stuck high at %0t ns", $time);
      errors++;
    end
  endtask

  task automatic send_frame(input int gap_max, input int n_words);
    word_t w;
    for (int i = 0; i < n_words; i++)
    begin
      for (int l = 0; l < `POOL_LANES; l++)
        w[l*`POOL_PIX_W +: `POOL_PIX_W] = frame[i*`POOL_LANES + l];
      if (gap_max > 0)
        repeat (int'(rand_bits()) % (gap_max + 1)) step();
      send_word(w);
    end
  endtask

  task automatic wait_words(input int n);
    int t;
    t = 0;
    while (rx_count < n && t < TIMEOUT)
    begin
      step();
      t++;
    end
    if (rx_count < n)
    begin
      $display("ERROR: timeout, only %0d of %0d output words arrived", rx_count, n);
      errors++;
    end
  endtask

  // kernel3 only changes here, after the previous frame is fully acked
  task automatic run_frame(input logic k3, input int gap_max, input int delay_max,
                           input bit quiet);
    int n_exp;
    kernel3 = k3;
    sink_delay_max = delay_max;
    rx_count = 0;
    exp_q.delete();
    pool_ref(frame, k3 ? 3 : 2);
    n_exp = exp_q.size();
    send_frame(gap_max, FRAME_WORDS);
    wait_words(n_exp);
    if (quiet)
    begin
      repeat (100) step();
      if (rx_count > n_exp)
      begin
        $display("ERROR: %0d extra output words after the frame", rx_count - n_exp);
        errors++;
      end
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == err0)
      $display("test %s: ok", name);
    else
    begin
      tests_failed++;
      $display("test %s: FAILED with %0d errors", name, errors - err0);
    end
  endtask

  // ******************************
  // output sink and compare
  // ******************************

  initial
  begin
    int d;
    int t;
    forever
    begin
      step();
      if (!reset && out_req && !out_ack)
      begin
        d = (sink_delay_max > 0) ? sink_rand(sink_delay_max + 1) : 0;
        repeat (d) step();
        got_q.push_back(out_data);
        out_ack = 1'b1;
        t = 0;
        while (out_req && t < TIMEOUT)
        begin
          step();
          t++;
        end
        if (out_req)
        begin
          $display("ERROR: out_req never dropped after out_ack at %0t ns", $time);
          errors++;
        end
        out_ack = 1'b0;
      end
    end
  end

  initial
  begin
    word_t w;
    word_t e;
    forever
    begin
      @(posedge clk);
      #2;
      while (got_q.size() > 0)
      begin
        w = got_q.pop_front();
        last_word = w;
        checks++;
        if (exp_q.size() == 0)
        begin
          $display("ERROR: unexpected output word %h at %0t ns", w, $time);
          errors++;
        end
        else
        begin
          e = exp_q.pop_front();
          if (w !== e)
          begin
            $display("[FAIL] %0t ns: word %0d got %h expected %h", $time, rx_count, w, e);
            errors++;
          end
        end
        rx_count++;
      end
    end
  end

  // ******************************
  // test sequence
  // ******************************

  initial
  begin
    reset   = 1'b1;
    kernel3 = 1'b0;
    in_req  = 1'b0;
    in_data = '0;
    out_ack = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;

    err0 = errors;
    fill_random();
    run_frame(1'b0, 0, 0, 1'b1);
    if (rx_count != 5)
    begin
      $display("[FAIL] %0t ns: 2x2 frame gave %0d words, expected 5", $time, rx_count);
      errors++;
    end
    if (last_word[63:32] != '0)
    begin
      $display("[FAIL] %0t ns: upper lanes of last word not zero: %h", $time, last_word);
      errors++;
    end
    end_test("random 2x2");

    err0 = errors;
    fill_random();
    run_frame(1'b1, 0, 0, 1'b1);
    if (rx_count != 2)
    begin
      $display("[FAIL] %0t ns: 3x3 frame gave %0d words, expected 2", $time, rx_count);
      errors++;
    end
    end_test("random 3x3");

    err0 = errors;
    fill_negative();
    run_frame(1'b0, 0, 0, 1'b0);
    run_frame(1'b1, 0, 0, 1'b1);
    end_test("signed values");

    err0 = errors;
    fill_random();
    run_frame(1'b0, 5, 7, 1'b1);
    fill_random();
    run_frame(1'b1, 5, 7, 1'b1);
    end_test("back-pressure");

    err0 = errors;
    for (int f = 0; f < 4; f++)
    begin
      fill_random();
      run_frame(f[0], 1, 2, f == 3); // alternate kernel per frame
    end
    end_test("back-to-back frames");

    // reset with a partial frame sitting in the line buffer
    err0 = errors;
    fill_random();
    kernel3 = 1'b0;
    sink_delay_max = 0;
    rx_count = 0;
    exp_q.delete();
    send_frame(0, 4);
    repeat (10) step();
    reset = 1'b1;
    repeat (3) step();
    reset = 1'b0;
    if (in_ack !== 1'b0 || out_req !== 1'b0)
    begin
      $display("[FAIL] %0t ns: in_ack %b out_req %b after reset", $time, in_ack, out_req);
      errors++;
    end
    if (got_q.size() != 0 || rx_count != 0)
    begin
      $display("[FAIL] %0t ns: output words seen from the aborted frame", $time);
      errors++;
    end
    fill_random();
    run_frame(1'b0, 0, 0, 1'b1);
    end_test("reset mid-frame");

    $display("tests run %0d, tests failed %0d, words checked %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

//--- verilog/pool_col_max.sv
// vertical stage: folds horizontal maxima of each kernel row through a line buffer
`timescale 1ns/1ps

`include "pool_defs.svh"

module pool_col_max
  import pool_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   kernel3,
  input  logic   pix_valid,
  input  pixel_t pix_data,
  input  logic   out_ready,
  output logic   pix_ready,
  output logic   out_valid,
  output pixel_t out_data,
  output logic   out_last
);

  col_cnt_t col;       // pooled column
  col_cnt_t kphase;    // kernel row phase
  col_cnt_t frow;      // pooled frame row
  col_cnt_t k_last;
  col_cnt_t col_last;
  col_cnt_t row_last;
  logic     first_row;
  logic     last_row;
  logic     xfer;
  pixel_t   lb_head;
  pixel_t   lb_in;
  pixel_t   col_max;
  logic     lb_push;
  logic     lb_pop;
  logic     lb_full;
  logic     lb_empty;

  assign k_last   = kernel3 ? col_cnt_t'(2) : col_cnt_t'(1);
  assign col_last = kernel3 ? col_cnt_t'(`POOL_ROW_PIX / 3 - 1) :
                              col_cnt_t'(`POOL_ROW_PIX / 2 - 1);
  assign row_last = kernel3 ? col_cnt_t'(`POOL_FRAME_ROWS / 3 - 1) :
                              col_cnt_t'(`POOL_FRAME_ROWS / 2 - 1);

  assign first_row = (kphase == '0);
  assign last_row  = (kphase == k_last);

  // first row needs room, later rows need a partial max waiting at the head
  assign pix_ready = first_row ? !lb_full :
                     (!lb_empty && (!last_row || !out_valid || out_ready));
  assign xfer      = pix_valid && pix_ready;

  assign col_max = (lb_head > pix_data) ? lb_head : pix_data;
  assign lb_in   = first_row ? pix_data : col_max;
  assign lb_push = xfer && !last_row;
  assign lb_pop  = xfer && !first_row;

  // ******************************
  // line buffer
  // ******************************

  pool_fifo #(
    .WIDTH (`POOL_PIX_W),
    .DEPTH (`POOL_LINE_DEPTH)
  ) line_buf (
    .clk      (clk),
    .reset    (reset),
    .push     (lb_push),
    .pop      (lb_pop),
    .data_in  (lb_in),
    .data_out (lb_head),
    .full     (lb_full),
    .empty    (lb_empty)
  );

  // ******************************
  // counters and output
  // ******************************

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      col       <= '0;
      kphase    <= '0;
      frow      <= '0;
      out_valid <= 1'b0;
    end
    else
    begin
      if (out_valid && out_ready)
        out_valid <= 1'b0;
      if (xfer)
      begin
        if (last_row)
          out_valid <= 1'b1;
        if (col == col_last)
        begin
          col <= '0;
          if (last_row)
          begin
            kphase <= '0;
            frow   <= (frow == row_last) ? '0 : frow + 1'b1;
          end
          else
            kphase <= kphase + 1'b1;
        end
        else
          col <= col + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (xfer && last_row)
    begin
      out_data <= col_max;
      out_last <= (col == col_last) && (frow == row_last); // frame end
    end
  end

endmodule

//--- verilog/pool_defs.svh
// frame geometry, pixel format and buffer depths; include wherever these sizes are needed
`ifndef POOL_DEFS_SVH
`define POOL_DEFS_SVH

// ******************************
// pixel format
// ******************************
`define POOL_PIX_W 16 // signed pixel bits
`define POOL_LANES 4  // pixels per bus word

// ******************************
// frame size, fixed at compile time
// ******************************
`define POOL_ROW_PIX    12 // divisible by both kernel sizes
`define POOL_FRAME_ROWS 6

// ******************************
// buffer depths
// ******************************
`define POOL_IN_DEPTH   8 // input words
`define POOL_LINE_DEPTH 8 // one pooled row at kernel 2 needs 6

`endif

//--- verilog/pool_fifo.sv
// first-word-fall-through FIFO; serves as the input word buffer and as the pooling line buffer
`timescale 1ns/1ps

`include "pool_defs.svh"

module pool_fifo #(
  parameter int WIDTH = `POOL_PIX_W,
  parameter int DEPTH = `POOL_LINE_DEPTH
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             push,
  input  logic             pop,
  input  logic [WIDTH-1:0] data_in,
  output logic [WIDTH-1:0] data_out,
  output logic             full,
  output logic             empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [CNT_W-1:0] count; // occupancy
  logic             do_push;
  logic             do_pop;

  assign do_push = push && !full; // writes into a full buffer are dropped
  assign do_pop  = pop && !empty;

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= data_in;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

  assign data_out = mem[rd_ptr]; // head always visible
  assign full     = (count == CNT_W'(DEPTH));
  assign empty    = (count == '0);

endmodule

//--- verilog/pool_ingress.sv
// four-phase input port; accepted words are queued and offered to the row stage by valid/ready
`timescale 1ns/1ps

`include "pool_defs.svh"

module pool_ingress
  import pool_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  in_req,
  input  word_t in_data,
  input  logic  word_ready,
  output logic  in_ack,
  output logic  word_valid,
  output word_t word_data
);

  hs_state_t state;
  logic      fifo_push;
  logic      fifo_pop;
  logic      fifo_full;
  logic      fifo_empty;

  // ******************************
  // four-phase receiver
  // ******************************

  // push once, on the edge that raises ack
  assign fifo_push = (state == hs_idle) && in_req && !fifo_full;

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= hs_idle;
    else
    begin
      case (state)
        hs_idle:
        begin
          if (fifo_push)
            state <= hs_busy;
        end
        hs_busy:
        begin
          if (!in_req) // source released, drop ack
            state <= hs_idle;
        end
        default:
          state <= hs_idle;
      endcase
    end
  end

  assign in_ack = (state == hs_busy);

  // ******************************
  // input buffer
  // ******************************

  pool_fifo #(
    .WIDTH ($bits(word_t)),
    .DEPTH (`POOL_IN_DEPTH)
  ) in_fifo (
    .clk      (clk),
    .reset    (reset),
    .push     (fifo_push),
    .pop      (fifo_pop),
    .data_in  (in_data),
    .data_out (word_data),
    .full     (fifo_full),
    .empty    (fifo_empty)
  );

  assign word_valid = !fifo_empty;
  assign fifo_pop   = word_valid && word_ready;

endmodule

//--- verilog/pool_pack.sv
// output stage: packs pooled pixels four per word and sends each word over a four-phase port
`timescale 1ns/1ps

`include "pool_defs.svh"

module pool_pack
  import pool_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   in_valid,
  input  pixel_t in_data,
  input  logic   in_last,
  input  logic   out_ack,
  output logic   in_ready,
  output logic   out_req,
  output word_t  out_data
);

  hs_state_t state;
  col_cnt_t  lane_cnt;   // next lane to fill
  word_t     word_q;
  logic      xfer;
  logic      word_done;

  assign in_ready  = (state == hs_idle); // no capture while a word is out
  assign xfer      = in_valid && in_ready;
  assign word_done = xfer && (in_last || (lane_cnt == col_cnt_t'(`POOL_LANES - 1)));

  // ******************************
  // lane fill
  // ******************************

  always_ff @(posedge clk)
  begin
    if (xfer)
    begin
      if (lane_cnt == '0)
        word_q <= word_t'($unsigned(in_data)); // clears the upper lanes for a short last word
      else
        word_q[lane_cnt*`POOL_PIX_W +: `POOL_PIX_W] <= in_data;
    end
  end

  // ******************************
  // four-phase sender
  // ******************************

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state    <= hs_idle;
      lane_cnt <= '0;
    end
    else
    begin
      case (state)
        hs_idle:
        begin
          if (word_done)
          begin
            lane_cnt <= '0;
            state    <= hs_busy;
          end
          else if (xfer)
            lane_cnt <= lane_cnt + 1'b1;
        end
        hs_busy:
        begin
          if (out_ack)
            state <= hs_release; // drop req
        end
        hs_release:
        begin
          if (!out_ack)
            state <= hs_idle;
        end
        default:
          state <= hs_idle;
      endcase
    end
  end

  assign out_req  = (state == hs_busy);
  assign out_data = word_q; // held since in_ready is low during the send

endmodule

//--- verilog/pool_pkg.sv
// shared types of the pooling engine; modules pull it in with a wildcard import

`include "pool_defs.svh"

package pool_pkg;

  // one signed pixel
  typedef logic signed [`POOL_PIX_W-1:0] pixel_t;

  // packed word, lane 0 in the low bits
  typedef logic [`POOL_LANES*`POOL_PIX_W-1:0] word_t;

  // column and row counters inside a frame
  typedef logic [3:0] col_cnt_t;

  // four-phase port state
  // hs_busy holds the req/ack line high, hs_release waits for the peer to drop
  typedef enum logic [1:0] {
    hs_idle,
    hs_busy,
    hs_release
  } hs_state_t;

endpackage

//--- verilog/pool_row_max.sv
// horizontal stage: unpacks words into pixels and emits the max of each 2- or 3-pixel window
`timescale 1ns/1ps

`include "pool_defs.svh"

module pool_row_max
  import pool_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   kernel3,
  input  logic   word_valid,
  input  word_t  word_data,
  input  logic   pix_ready,
  output logic   word_ready,
  output logic   pix_valid,
  output pixel_t pix_data
);

  localparam int LANE_W = $clog2(`POOL_LANES + 1);

  word_t       shift_q;    // lane shifter, lane 0 is the current pixel
  logic [LANE_W-1:0] lanes_left;
  pixel_t      cur_pix;
  pixel_t      run_max;    // max so far in the open window
  pixel_t      win_max;
  col_cnt_t    win_cnt;    // position inside the window
  col_cnt_t    win_last;
  logic        take;       // current pixel consumed this cycle
  logic        win_done;

  assign cur_pix  = shift_q[`POOL_PIX_W-1:0];
  assign win_last = kernel3 ? col_cnt_t'(2) : col_cnt_t'(1);

  // stall only when the output register is full and not draining
  assign take       = (lanes_left != '0) && (!pix_valid || pix_ready);
  assign win_done   = take && (win_cnt == win_last);
  assign word_ready = (lanes_left == '0) || ((lanes_left == LANE_W'(1)) && take);

  // signed compare, first pixel of a window restarts the max
  assign win_max = ((win_cnt == '0) || (cur_pix > run_max)) ? cur_pix : run_max;

  // ******************************
  // control
  // ******************************

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      lanes_left <= '0;
      win_cnt    <= '0;
      pix_valid  <= 1'b0;
    end
    else
    begin
      if (pix_valid && pix_ready)
        pix_valid <= 1'b0;
      if (win_done)
      begin
        win_cnt   <= '0;
        pix_valid <= 1'b1;
      end
      else if (take)
        win_cnt <= win_cnt + 1'b1;

      if (word_valid && word_ready)
        lanes_left <= LANE_W'(`POOL_LANES); // reload beats the last shift
      else if (take)
        lanes_left <= lanes_left - 1'b1;
    end
  end

  // ******************************
  // datapath
  // ******************************

  always_ff @(posedge clk)
  begin
    if (word_valid && word_ready)
      shift_q <= word_data;
    else if (take)
      shift_q <= shift_q >> `POOL_PIX_W;

    if (take)
      run_max <= win_max;
    if (win_done)
      pix_data <= win_max;
  end

endmodule

//--- verilog/pool_top.sv
// max-pooling engine top; chains ingress, horizontal max, vertical max and output packing
`timescale 1ns/1ps

module pool_top
  import pool_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  kernel3,
  input  logic  in_req,
  input  word_t in_data,
  input  logic  out_ack,
  output logic  in_ack,
  output logic  out_req,
  output word_t out_data
);

  // ingress to row stage
  logic   word_valid;
  logic   word_ready;
  word_t  word_data;

  // row stage to column stage
  logic   hmax_valid;
  logic   hmax_ready;
  pixel_t hmax_data;

  // column stage to packer
  logic   pool_valid;
  logic   pool_ready;
  pixel_t pool_data;
  logic   pool_last;

  pool_ingress ingress_inst (
    .clk        (clk),
    .reset      (reset),
    .in_req     (in_req),
    .in_data    (in_data),
    .word_ready (word_ready),
    .in_ack     (in_ack),
    .word_valid (word_valid),
    .word_data  (word_data)
  );

  pool_row_max row_max_inst (
    .clk        (clk),
    .reset      (reset),
    .kernel3    (kernel3),
    .word_valid (word_valid),
    .word_data  (word_data),
    .pix_ready  (hmax_ready),
    .word_ready (word_ready),
    .pix_valid  (hmax_valid),
    .pix_data   (hmax_data)
  );

  pool_col_max col_max_inst (
    .clk       (clk),
    .reset     (reset),
    .kernel3   (kernel3),
    .pix_valid (hmax_valid),
    .pix_data  (hmax_data),
    .out_ready (pool_ready),
    .pix_ready (hmax_ready),
    .out_valid (pool_valid),
    .out_data  (pool_data),
    .out_last  (pool_last)
  );

  pool_pack pack_inst (
    .clk      (clk),
    .reset    (reset),
    .in_valid (pool_valid),
    .in_data  (pool_data),
    .in_last  (pool_last),
    .out_ack  (out_ack),
    .in_ready (pool_ready),
    .out_req  (out_req),
    .out_data (out_data)
  );

endmodule
